// File: design/pit_bus_decode.sv
/*
 * register bus decoder, strobe routing per channel and mixer,
 * control word channel select, registered read data with valid flag
 */
`timescale 1ns/1ns
`default_nettype none

module pit_bus_decode
    import pit_bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [1:0]        addr,
    input  logic              wr,
    input  logic              rd,
    input  logic [DATA_W-1:0] wdata,
    output logic              cw_set0,
    output logic              cw_set1,
    output logic [5:0]        cw,
    output logic              load_wr0,
    output logic              load_wr1,
    output logic              load_rd0,
    output logic              load_rd1,
    output logic              mute_wr,
    input  logic [1:0]        mute_bits,
    input  logic [DATA_W-1:0] rbyte0,
    input  logic [DATA_W-1:0] rbyte1,
    output logic [DATA_W-1:0] rdata,
    output logic              rdata_valid
);

    reg_addr_t         addr_e;
    logic              ctrl_wr;     // write to the control register
    logic [DATA_W-1:0] rd_sel;      // byte picked by the current address

    assign addr_e  = reg_addr_t'(addr);
    assign ctrl_wr = wr && (addr_e == ADDR_CTRL);

    // top two bits pick the channel, 2 and 3 go nowhere
    assign cw_set0 = ctrl_wr && (wdata[7:6] == 2'd0);
    assign cw_set1 = ctrl_wr && (wdata[7:6] == 2'd1);
    assign cw      = wdata[5:0];   // mode, access and bcd bits

    assign load_wr0 = wr && (addr_e == ADDR_CNT0);
    assign load_wr1 = wr && (addr_e == ADDR_CNT1);
    assign load_rd0 = rd && (addr_e == ADDR_CNT0);  // advances the byte pointer
    assign load_rd1 = rd && (addr_e == ADDR_CNT1);
    assign mute_wr  = wr && (addr_e == ADDR_MUTE);

    always_comb
    begin
        case (addr_e)
            ADDR_CNT0: rd_sel = rbyte0;
            ADDR_CNT1: rd_sel = rbyte1;
            ADDR_MUTE: rd_sel = {{(DATA_W-2){1'b0}}, mute_bits};
            default:   rd_sel = '0;                 // control reads as 0
        endcase
    end

    // read data one cycle after the strobe
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            rdata_valid <= 1'b0;
        else
            rdata_valid <= rd;
    end

    always_ff @(posedge clk)
    begin
        if (rd)
            rdata <= rd_sel;
    end

endmodule

`default_nettype wire

// File: design/pit_bus_pkg.sv
/*
 * register map and byte width of the PIT register bus
 */
`default_nettype none

package pit_bus_pkg;

    localparam int DATA_W = 8;  // bus byte

    typedef enum logic [1:0] {
        ADDR_CNT0 = 2'd0,       // channel 0 count
        ADDR_CNT1 = 2'd1,       // channel 1 count
        ADDR_MUTE = 2'd2,       // mixer mute bits
        ADDR_CTRL = 2'd3        // control word, reads back 0
    } reg_addr_t;

endpackage

`default_nettype wire

// File: design/pit_counter_unit.sv
/*
 * one timer channel: control word register, count load sequencing,
 * start and stop timing, output waveform per mode
 */
`timescale 1ns/1ns
`default_nettype none

module pit_counter_unit
    import pit_mode_pkg::*, pit_bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              tick,
    input  logic              cw_set,
    input  logic [5:0]        cw,
    input  logic              load_wr,
    input  logic              load_rd,
    input  logic [DATA_W-1:0] wdata,
    output logic [DATA_W-1:0] rbyte,
    output logic              out
);

    logic [5:0]    cw_q;            // access, mode, bcd (bcd kept, not used)
    counter_mode_t mode;
    access_mode_t  acc;
    counter_mode_t cw_mode;         // mode field of an incoming word
    access_mode_t  cw_acc;
    logic          mode_cmd;        // a real control word for this channel
    logic          latch_cmd;
    logic          is_rate;
    logic          is_square;
    logic          one_shot;        // modes 0 and 4
    logic          no_run;          // modes 1 and 5 never start
    logic [15:0]   load_value;
    logic [15:0]   count;
    logic          write_msb;       // next ACC_WORD write is the high byte
    logic          loading;         // between the two bytes of a word load
    logic          running;
    logic          pend_load;       // load waits for the next tick
    logic          final_byte;
    logic          load_now;
    logic          cnt_en;
    logic          eval;

    assign mode    = counter_mode_t'(cw_q[3:1]);
    assign acc     = access_mode_t'(cw_q[5:4]);
    assign cw_mode = counter_mode_t'(cw[3:1]);
    assign cw_acc  = access_mode_t'(cw[5:4]);

    assign latch_cmd = cw_set && (cw_acc == ACC_LATCH);   // mode left alone
    assign mode_cmd  = cw_set && (cw_acc != ACC_LATCH);

    assign is_rate   = (mode == MODE_RATE2)   || (mode == MODE_RATE2X);
    assign is_square = (mode == MODE_SQUARE3) || (mode == MODE_SQUARE3X);
    assign one_shot  = (mode == MODE_INT0)    || (mode == MODE_STROBE4);
    assign no_run    = (mode == MODE_ONESHOT1) || (mode == MODE_HWSTROBE5);

    always_comb
    begin
        case (acc)
            ACC_LSB, ACC_MSB: final_byte = load_wr;
            ACC_WORD:         final_byte = load_wr && write_msb;
            default:          final_byte = 1'b0;   // unprogrammed channel
        endcase
    end

    // a write in the tick cycle defers the load by one tick
    assign load_now = tick && pend_load && !load_wr;
    // modes 0 and 4 freeze between the two bytes of a word load
    assign cnt_en   = tick && running && !(loading && one_shot);
    assign eval     = tick && running && !load_now;

    // ------------------------------------------------------------------------
    // load value assembly
    // ------------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (load_wr)
        begin
            case (acc)
                ACC_LSB: load_value <= {8'h00, wdata};     // msb cleared
                ACC_MSB: load_value <= {wdata, 8'h00};     // lsb cleared
                ACC_WORD:
                begin
                    if (write_msb)
                        load_value[15:8] <= wdata;
                    else
                        load_value[7:0] <= wdata;
                end
                default: ;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // control state and output
    // ------------------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cw_q      <= '0;
            write_msb <= 1'b0;
            loading   <= 1'b0;
            running   <= 1'b0;
            pend_load <= 1'b0;
            out       <= 1'b0;
        end
        else if (mode_cmd)
        begin
            cw_q      <= cw;
            write_msb <= 1'b0;
            loading   <= 1'b0;
            running   <= 1'b0;            // idle until a count arrives
            pend_load <= 1'b0;
            out       <= (cw_mode != MODE_INT0);
        end
        else
        begin
            if (load_wr && (acc == ACC_WORD))
            begin
                write_msb <= !write_msb;
                loading   <= !write_msb;  // set on lsb, cleared on msb
            end
            // modes 2 and 3 pick up a new count at their next reload
            if (final_byte && !no_run && (!running || one_shot))
                pend_load <= 1'b1;
            if (load_now)
            begin
                pend_load <= 1'b0;
                running   <= 1'b1;
            end
            if (eval)
            begin
                case (mode)
                    MODE_INT0:                   if (count == 16'd1) out <= 1'b1;
                    MODE_RATE2, MODE_RATE2X:     out <= (count != 16'd2);
                    MODE_SQUARE3, MODE_SQUARE3X: if (count == 16'd2) out <= !out;
                    MODE_STROBE4:                out <= (count != 16'd0);
                    default: ;                   // modes 1 and 5 hold
                endcase
            end
        end
    end

    pit_downcounter u_dcnt (
        .clk        (clk),
        .tick       (cnt_en),
        .half_step  (is_square),
        .auto_reload(is_rate || is_square),
        .out_now    (out),
        .load_value (load_value),
        .load       (load_now),
        .count      (count)
    );

    pit_read_latch u_rlatch (
        .clk      (clk),
        .rst_n    (rst_n),
        .load_rd  (load_rd),
        .latch_cmd(latch_cmd),
        .new_mode (mode_cmd),
        .access   (acc),
        .count    (count),
        .rbyte    (rbyte)
    );

endmodule

`default_nettype wire

// File: design/pit_downcounter.sv
/*
 * 16-bit down counter, synchronous load, auto reload,
 * double step for the square wave
 */
`timescale 1ns/1ns
`default_nettype none

module pit_downcounter (
    input  logic        clk,
    input  logic        tick,           // gated count enable
    input  logic        half_step,      // square wave, step by 2
    input  logic        auto_reload,
    input  logic        out_now,        // current channel output
    input  logic [15:0] load_value,
    input  logic        load,
    output logic [15:0] count
);

    logic [15:0] step;
    logic [15:0] next;

    // odd count in square mode: 1 while out is high, 3 while low
    always_comb
    begin
        if (!half_step)
            step = 16'd1;
        else if (!count[0])
            step = 16'd2;
        else if (out_now)
            step = 16'd1;
        else
            step = 16'd3;
    end

    assign next = count - step;

    always_ff @(posedge clk)
    begin
        if (load)
            count <= load_value;
        else if (tick)
            count <= (auto_reload && (next == 16'd0)) ? load_value : next;   // wraps otherwise
    end

endmodule

`default_nettype wire

// File: design/pit_mode_pkg.sv
/*
 * counter mode and access-mode encodings of the PIT control word
 * shared by the channel, read latch and counter modules
 */
`default_nettype none

package pit_mode_pkg;

    // mode field, cw[3:1]
    typedef enum logic [2:0] {
        MODE_INT0      = 3'd0,  // interrupt on terminal count
        MODE_ONESHOT1  = 3'd1,  // gate triggered, counter stays idle
        MODE_RATE2     = 3'd2,  // rate generator
        MODE_SQUARE3   = 3'd3,  // square wave
        MODE_STROBE4   = 3'd4,  // software strobe
        MODE_HWSTROBE5 = 3'd5,  // gate triggered, counter stays idle
        MODE_RATE2X    = 3'd6,  // alias of mode 2
        MODE_SQUARE3X  = 3'd7   // alias of mode 3
    } counter_mode_t;

    // access field, cw[5:4]
    typedef enum logic [1:0] {
        ACC_LATCH = 2'd0,       // counter latch command, not a mode
        ACC_LSB   = 2'd1,       // low byte only
        ACC_MSB   = 2'd2,       // high byte only
        ACC_WORD  = 2'd3        // low byte then high byte
    } access_mode_t;

endpackage

`default_nettype wire

// File: design/pit_read_latch.sv
/*
 * count read path: latch command holding register,
 * byte order of live and latched reads per access mode
 */
`timescale 1ns/1ns
`default_nettype none

module pit_read_latch
    import pit_mode_pkg::*, pit_bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              load_rd,
    input  logic              latch_cmd,
    input  logic              new_mode,
    input  access_mode_t      access,
    input  logic [15:0]       count,
    output logic [DATA_W-1:0] rbyte
);

    logic [15:0] latched_q;         // frozen count
    logic [1:0]  latch_left;        // reads still served from latched_q
    logic        read_msb;          // next word read returns the high byte
    logic        sel_msb;
    logic [15:0] src;

    assign src     = (latch_left != 2'd0) ? latched_q : count;
    assign sel_msb = (access == ACC_MSB) || ((access == ACC_WORD) && read_msb);
    assign rbyte   = sel_msb ? src[15:8] : src[7:0];

    always_ff @(posedge clk)
    begin
        if (latch_cmd)
            latched_q <= count;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            latch_left <= 2'd0;
            read_msb   <= 1'b0;
        end
        else if (new_mode)
        begin
            latch_left <= 2'd0;     // a new mode drops any pending latch
            read_msb   <= 1'b0;
        end
        else if (latch_cmd)
            latch_left <= 2'd2;
        else if (load_rd)
        begin
            if (latch_left != 2'd0)
                latch_left <= latch_left - 2'd1;
            if (access == ACC_WORD)
                read_msb <= !read_msb;
        end
    end

endmodule

`default_nettype wire

// File: design/pit_sound_mixer.sv
/*
 * sound mixer: per-channel mute register, registered sum of the outputs
 */
`timescale 1ns/1ns
`default_nettype none

module pit_sound_mixer
    import pit_bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mute_wr,
    input  logic [DATA_W-1:0] wdata,      // bits 1:0 only
    input  logic              out0,
    input  logic              out1,
    output logic [1:0]        mute_bits,
    output logic [1:0]        level
);

    logic [1:0] lvl_next;

    // a muted channel counts as 0
    assign lvl_next = {1'b0, out0 && !mute_bits[0]} + {1'b0, out1 && !mute_bits[1]};

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            mute_bits <= 2'b00;
            level     <= 2'd0;
        end
        else
        begin
            if (mute_wr)
                mute_bits <= wdata[1:0];
            level <= lvl_next;          // one cycle behind the outs
        end
    end

endmodule

`default_nettype wire

// File: design/pit_tick_gen.sv
/*
 * timer tick generator, one clk-wide pulse every TICK_DIV cycles
 */
`timescale 1ns/1ns
`default_nettype none

module pit_tick_gen #(
    parameter int TICK_DIV = 4      // clk cycles per tick, at least 2
) (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    localparam int CNT_W = $clog2(TICK_DIV);

    logic [CNT_W-1:0] div_cnt;      // wraps at TICK_DIV-1

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end
        else if (div_cnt == CNT_W'(TICK_DIV - 1))
        begin
            div_cnt <= '0;
            tick    <= 1'b1;        // last count of the period
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: design/pit_top.sv
/*
 * two-channel sound timer top: tick generator, bus decoder,
 * channels 0 and 1, mixer
 */
`timescale 1ns/1ns
`default_nettype none

module pit_top
    import pit_bus_pkg::*;
#(
    parameter int TICK_DIV = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [1:0]        addr,
    input  logic              wr,
    input  logic              rd,
    input  logic [DATA_W-1:0] wdata,
    output logic [DATA_W-1:0] rdata,
    output logic              rdata_valid,
    output logic              out0,
    output logic              out1,
    output logic [1:0]        level
);

    logic              tick;
    logic              cw_set0;
    logic              cw_set1;
    logic [5:0]        cw;
    logic              load_wr0;
    logic              load_wr1;
    logic              load_rd0;
    logic              load_rd1;
    logic              mute_wr;
    logic [1:0]        mute_bits;
    logic [DATA_W-1:0] rbyte0;
    logic [DATA_W-1:0] rbyte1;

    pit_tick_gen #(.TICK_DIV(TICK_DIV)) u_tick (
        .clk  (clk),
        .rst_n(rst_n),
        .tick (tick)
    );

    pit_bus_decode u_dec (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (addr),
        .wr         (wr),
        .rd         (rd),
        .wdata      (wdata),
        .cw_set0    (cw_set0),
        .cw_set1    (cw_set1),
        .cw         (cw),
        .load_wr0   (load_wr0),
        .load_wr1   (load_wr1),
        .load_rd0   (load_rd0),
        .load_rd1   (load_rd1),
        .mute_wr    (mute_wr),
        .mute_bits  (mute_bits),
        .rbyte0     (rbyte0),
        .rbyte1     (rbyte1),
        .rdata      (rdata),
        .rdata_valid(rdata_valid)
    );

    // ------------------------------------------------------------------------
    // channels share the tick, cw and write data
    // ------------------------------------------------------------------------
    pit_counter_unit u_ch0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .tick   (tick),
        .cw_set (cw_set0),
        .cw     (cw),
        .load_wr(load_wr0),
        .load_rd(load_rd0),
        .wdata  (wdata),
        .rbyte  (rbyte0),
        .out    (out0)
    );

    pit_counter_unit u_ch1 (
        .clk    (clk),
        .rst_n  (rst_n),
        .tick   (tick),
        .cw_set (cw_set1),
        .cw     (cw),
        .load_wr(load_wr1),
        .load_rd(load_rd1),
        .wdata  (wdata),
        .rbyte  (rbyte1),
        .out    (out1)
    );

    pit_sound_mixer u_mix (
        .clk      (clk),
        .rst_n    (rst_n),
        .mute_wr  (mute_wr),
        .wdata    (wdata),
        .out0     (out0),
        .out1     (out1),
        .mute_bits(mute_bits),
        .level    (level)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and decide pass or fail from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_pit -o tb_pit_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_pit_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test OK$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: tb.f
+incdir+testbench
design/pit_mode_pkg.sv
design/pit_bus_pkg.sv
design/pit_tick_gen.sv
design/pit_bus_decode.sv
design/pit_downcounter.sv
design/pit_read_latch.sv
design/pit_counter_unit.sv
design/pit_sound_mixer.sv
design/pit_top.sv
testbench/tb_pit.sv

// File: testbench/tb_pit_model.svh
/*
 * clk-level reference model of the sound timer
 * tick divider, both channels with read sequencing, mute and level
 */
`ifndef TB_PIT_MODEL_SVH
`define TB_PIT_MODEL_SVH

int          m_div;                 // clk cycles since the last tick
logic        m_tick;
logic [2:0]  m_mode      [2];
logic [1:0]  m_acc       [2];       // 0 until a control word arrives
logic        m_hi_next   [2];       // next word byte written is the high one
logic        m_half      [2];       // low byte in, high byte still missing
logic        m_run       [2];
logic        m_pend      [2];       // count waits for a tick to start
logic        m_out       [2];
logic [15:0] m_load      [2];
logic [15:0] m_count     [2];
logic [15:0] m_frozen    [2];       // value held by a latch command
int          m_frozen_left [2];
logic        m_rd_hi     [2];       // next word read returns the high byte
logic [1:0]  m_mute;
logic [1:0]  m_level;
logic        m_rvalid;
logic [7:0]  m_rdata;

task automatic channel_reset(input logic ch);
    m_mode[ch]        = 3'd0;
    m_acc[ch]         = 2'd0;
    m_hi_next[ch]     = 1'b0;
    m_half[ch]        = 1'b0;
    m_run[ch]         = 1'b0;
    m_pend[ch]        = 1'b0;
    m_out[ch]         = 1'b0;
    m_frozen_left[ch] = 0;
    m_rd_hi[ch]       = 1'b0;
endtask

task automatic model_reset();
    m_div    = 0;
    m_tick   = 1'b0;
    m_mute   = 2'b00;
    m_level  = 2'd0;
    m_rvalid = 1'b0;
    channel_reset(1'b0);
    channel_reset(1'b1);
endtask

// byte a count read returns right now
function automatic logic [7:0] count_byte(input logic ch);
    logic [15:0] src;
    src = (m_frozen_left[ch] != 0) ? m_frozen[ch] : m_count[ch];
    if ((m_acc[ch] == ACC_MSB) || ((m_acc[ch] == ACC_WORD) && m_rd_hi[ch]))
        return src[15:8];
    return src[7:0];
endfunction

// ---------------------------------------------------------------------------
// steps one channel by one clk edge from the state before that edge
// ---------------------------------------------------------------------------
task automatic channel_step(input logic ch, input logic cw_hit, input logic ld_wr,
                            input logic ld_rd, input logic [7:0] d);
    logic        reloads;
    logic        square;
    logic        single;
    logic        stalled;
    logic        latch;
    logic        new_mode;
    logic        last;
    logic        start;
    logic        step_en;
    logic        judge;
    logic [15:0] old_cnt;
    logic [15:0] dec;
    logic [15:0] nxt;

    reloads  = m_mode[ch][1];                        // modes 2, 3, 6, 7
    square   = m_mode[ch][1] & m_mode[ch][0];        // modes 3 and 7
    single   = !m_mode[ch][1] & !m_mode[ch][0];      // modes 0 and 4
    stalled  = !m_mode[ch][1] & m_mode[ch][0];       // modes 1 and 5 never run
    latch    = cw_hit && (d[5:4] == ACC_LATCH);
    new_mode = cw_hit && (d[5:4] != ACC_LATCH);
    last     = ld_wr && ((m_acc[ch] == ACC_LSB) || (m_acc[ch] == ACC_MSB) ||
                         ((m_acc[ch] == ACC_WORD) && m_hi_next[ch]));
    start    = m_tick && m_pend[ch] && !ld_wr;       // a write on the tick delays the start
    step_en  = m_tick && m_run[ch] && !(m_half[ch] && single);
    judge    = m_tick && m_run[ch] && !start;
    old_cnt  = m_count[ch];

    if (latch)
        m_frozen[ch] = old_cnt;
    if (new_mode)
    begin
        m_frozen_left[ch] = 0;
        m_rd_hi[ch]       = 1'b0;
    end
    else if (latch)
        m_frozen_left[ch] = 2;                       // next two reads see the frozen value
    else if (ld_rd)
    begin
        if (m_frozen_left[ch] != 0)
            m_frozen_left[ch] = m_frozen_left[ch] - 1;
        if (m_acc[ch] == ACC_WORD)
            m_rd_hi[ch] = !m_rd_hi[ch];
    end

    if (start)
        m_count[ch] = m_load[ch];
    else if (step_en)
    begin
        if (!square)
            dec = 16'd1;
        else if (!old_cnt[0])
            dec = 16'd2;
        else
            dec = m_out[ch] ? 16'd1 : 16'd3;         // odd count lengthens the high half
        nxt = old_cnt - dec;
        m_count[ch] = (reloads && (nxt == 16'd0)) ? m_load[ch] : nxt;
    end

    if (ld_wr)
    begin
        if (m_acc[ch] == ACC_LSB)
            m_load[ch] = {8'h00, d};
        else if (m_acc[ch] == ACC_MSB)
            m_load[ch] = {d, 8'h00};
        else if ((m_acc[ch] == ACC_WORD) && m_hi_next[ch])
            m_load[ch][15:8] = d;
        else if (m_acc[ch] == ACC_WORD)
            m_load[ch][7:0] = d;
    end

    if (new_mode)
    begin
        m_mode[ch]    = d[3:1];
        m_acc[ch]     = d[5:4];
        m_hi_next[ch] = 1'b0;
        m_half[ch]    = 1'b0;
        m_run[ch]     = 1'b0;                        // waits for a new count
        m_pend[ch]    = 1'b0;
        m_out[ch]     = (d[3:1] != 3'd0);            // only mode 0 starts low
    end
    else
    begin
        if (judge)
        begin
            case (m_mode[ch])
                MODE_INT0:                   if (old_cnt == 16'd1) m_out[ch] = 1'b1;
                MODE_RATE2, MODE_RATE2X:     m_out[ch] = (old_cnt != 16'd2);
                MODE_SQUARE3, MODE_SQUARE3X: if (old_cnt == 16'd2) m_out[ch] = !m_out[ch];
                MODE_STROBE4:                m_out[ch] = (old_cnt != 16'd0);
                default: ;
            endcase
        end
        if (ld_wr && (m_acc[ch] == ACC_WORD))
        begin
            m_half[ch]    = !m_hi_next[ch];
            m_hi_next[ch] = !m_hi_next[ch];
        end
        if (last && !stalled && (!m_run[ch] || single))
            m_pend[ch] = 1'b1;                       // modes 2 and 3 take it at reload
        if (start)
        begin
            m_pend[ch] = 1'b0;
            m_run[ch]  = 1'b1;
        end
    end
endtask

// whole design at one clk edge with the bus inputs sampled there
task automatic model_step(input logic [1:0] a, input logic w, input logic r,
                          input logic [7:0] d);
    m_rvalid = r;
    if (r)
    begin
        case (a)
            ADDR_CNT0: m_rdata = count_byte(1'b0);
            ADDR_CNT1: m_rdata = count_byte(1'b1);
            ADDR_MUTE: m_rdata = {6'b000000, m_mute};
            default:   m_rdata = 8'h00;
        endcase
    end
    m_level = 2'(m_out[0] & !m_mute[0]) + 2'(m_out[1] & !m_mute[1]);
    if (w && (a == ADDR_MUTE))
        m_mute = d[1:0];
    channel_step(1'b0, w && (a == ADDR_CTRL) && (d[7:6] == 2'd0), w && (a == ADDR_CNT0),
                 r && (a == ADDR_CNT0), d);
    channel_step(1'b1, w && (a == ADDR_CTRL) && (d[7:6] == 2'd1), w && (a == ADDR_CNT1),
                 r && (a == ADDR_CNT1), d);
    m_tick = (m_div == TICK_DIV - 1);                // tick is a registered pulse
    m_div  = m_tick ? 0 : m_div + 1;
endtask

`endif

// File: testbench/tb_pit.sv
/*
 * testbench for the two-channel sound timer
 * clock, reset, LFSR driven scenarios, per-cycle comparison against
 * the reference model, timeout
 */
`timescale 1ns/1ns
`default_nettype none

module tb_pit
    import pit_mode_pkg::*, pit_bus_pkg::*;
();

    localparam int TICK_DIV    = 3;
    localparam int N_SCEN      = 20;
    localparam int N_OPS       = 40;
    localparam int SCEN_CYCLES = 750;               // setup plus N_OPS ops of at most 17 cycles
    localparam int CYCLE_LIMIT = N_SCEN * SCEN_CYCLES + 100;

    logic        clk;
    logic        rst_n;
    logic [1:0]  addr;
    logic        wr;
    logic        rd;
    logic [7:0]  wdata;
    logic [7:0]  rdata;
    logic        rdata_valid;
    logic        out0;
    logic        out1;
    logic [1:0]  level;

    logic [31:0]  lfsr_q;
    int           cycle_cnt;
    access_mode_t ch_acc [2];                       // access mode last given to each channel

    `include "tb_pit_model.svh"

    pit_top #(.TICK_DIV(TICK_DIV)) i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (addr),
        .wr         (wr),
        .rd         (rd),
        .wdata      (wdata),
        .rdata      (rdata),
        .rdata_valid(rdata_valid),
        .out0       (out0),
        .out1       (out1),
        .level      (level)
    );

    always #20 clk = ~clk;                          // 40 ns period

    // ------------------------------------------------------------------------
    // failure reporting
    // ------------------------------------------------------------------------
    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic value_error(input string msg);
        fail_run($sformatf("ERR %0t: %s", $time, msg));
    endtask

    // ------------------------------------------------------------------------
    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        int i;
        v = 0;
        for (i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);             // one step per bit
            v = (v << 1) | int'(lfsr_q[0]);
        end
        return v;
    endfunction

    function automatic logic [2:0] pick_mode();
        int sel;
        int alt;
        sel = rand_bits(2);
        alt = rand_bits(1);                         // modes 6 and 7 now and then
        case (sel)
            0:       return MODE_INT0;
            1:       return (alt != 0) ? MODE_RATE2X : MODE_RATE2;
            2:       return (alt != 0) ? MODE_SQUARE3X : MODE_SQUARE3;
            default: return MODE_STROBE4;
        endcase
    endfunction

    function automatic access_mode_t pick_access();
        int a;
        a = rand_bits(2);
        return (a == 0) ? ACC_WORD : access_mode_t'(2'(a));   // 0 would be a latch
    endfunction

    function automatic logic [15:0] pick_count();
        return 16'(2 + rand_bits(6) % 39);          // 2 to 40
    endfunction

    // ------------------------------------------------------------------------
    // bus tasks with single-cycle strobes
    // ------------------------------------------------------------------------
    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
        @(posedge clk);
        addr  <= a;
        wdata <= d;
        wr    <= 1'b1;
        @(posedge clk);
        wr    <= 1'b0;
    endtask

    task automatic bus_read(input logic [1:0] a);
        int waited;
        @(posedge clk);
        addr <= a;
        rd   <= 1'b1;
        @(posedge clk);
        rd   <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!rdata_valid && (waited < 4))
        begin
            @(negedge clk);
            waited++;
        end
        if (!rdata_valid)
            fail_run("read strobe got no rdata_valid within 4 cycles");
    endtask

    task automatic program_channel(input logic ch, input logic [2:0] mode,
                                   input access_mode_t acc);
        bus_write(ADDR_CTRL, {1'b0, ch, acc, mode, 1'(rand_bits(1))});  // bcd bit ignored
        ch_acc[ch] = acc;
    endtask

    task automatic load_count(input logic ch, input logic [15:0] value, input int gap);
        case (ch_acc[ch])
            ACC_LSB: bus_write({1'b0, ch}, value[7:0]);
            ACC_MSB: bus_write({1'b0, ch}, 8'(1 + rand_bits(1)));  // 256 or 512 ticks
            default:
            begin
                bus_write({1'b0, ch}, value[7:0]);
                idle(gap);                          // modes 0 and 4 freeze here
                bus_write({1'b0, ch}, value[15:8]);
            end
        endcase
    endtask

    task automatic run_random_op();
        logic ch;
        int   op;
        ch = 1'(rand_bits(1));
        op = rand_bits(3);
        case (op)
            0: idle(1 + rand_bits(4));
            1: bus_read({1'b0, ch});                // live or latched count byte
            2: bus_write(ADDR_CTRL, {1'b0, ch, 6'b000000});  // latch command
            3: load_count(ch, pick_count(), rand_bits(3));
            4:
            begin
                bus_write(ADDR_MUTE, {6'b000000, 2'(rand_bits(2))});
                bus_read(ADDR_MUTE);
            end
            5:
            begin
                bus_write(ADDR_CTRL, {1'b1, 7'(rand_bits(7))});   // channel 2 or 3, dropped
                bus_read(ADDR_CTRL);
            end
            6:
            begin
                program_channel(ch, pick_mode(), pick_access());
                load_count(ch, pick_count(), rand_bits(3));
            end
            default:
            begin
                bus_read({1'b0, ch});
                bus_read({1'b0, ch});
            end
        endcase
    endtask

    // ------------------------------------------------------------------------
    // model, checks and timeout
    // ------------------------------------------------------------------------
    always @(posedge clk)
    begin
        if (!rst_n)
            model_reset();
        else
            model_step(addr, wr, rd, wdata);        // same inputs the DUT samples
    end

    always @(negedge clk)
    begin
        if (cycle_cnt > 0)
        begin
            assert (out0 == m_out[0])
                else value_error($sformatf("out0 is %b, expected %b", out0, m_out[0]));
            assert (out1 == m_out[1])
                else value_error($sformatf("out1 is %b, expected %b", out1, m_out[1]));
            assert (level == m_level)
                else value_error($sformatf("level is %0d, expected %0d", level, m_level));
            assert (rdata_valid == m_rvalid)
                else value_error($sformatf("rdata_valid is %b, expected %b",
                                           rdata_valid, m_rvalid));
            if (m_rvalid)
            begin
                assert (rdata == m_rdata)
                    else value_error($sformatf("rdata is %h, expected %h", rdata, m_rdata));
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
            fail_run($sformatf("timeout, run still going after %0d cycles", CYCLE_LIMIT));
    end

    // ------------------------------------------------------------------------
    // scenarios
    // ------------------------------------------------------------------------
    initial
    begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        addr      = 2'd0;
        wr        = 1'b0;
        rd        = 1'b0;
        wdata     = 8'h00;
        cycle_cnt = 0;
        lfsr_q    = 32'h4ac8_a9e6;
        ch_acc[0] = ACC_LATCH;
        ch_acc[1] = ACC_LATCH;

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        idle(4);                                    // outputs stay 0 while untouched

        for (int s = 0; s < N_SCEN; s++)
        begin
            program_channel(1'b0, pick_mode(), pick_access());
            load_count(1'b0, pick_count(), rand_bits(3));
            program_channel(1'b1, pick_mode(), pick_access());
            load_count(1'b1, pick_count(), rand_bits(3));
            idle(2 * TICK_DIV);                     // both counts loaded before any read
            for (int k = 0; k < N_OPS; k++)
                run_random_op();
        end

        idle(4);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
